// ==== build.f ====
verilog/gap_fc_pkg.sv
verilog/chan_buf_if.sv
verilog/param_regs.sv
verilog/gap_pool.sv
verilog/chan_pingpong.sv
verilog/fc_layer.sv
verilog/gap_fc_top.sv
tb/tb_gap_fc.sv

// ==== tb/gap_fc_stim.txt ====
# w sel addr data: parameter write (sel 0 weights, 1 fc requant, 2 bias, 3 pool requant)
# m base n bytes: feature map, e r0 r1 r2 r3: expected results, s pix base: start, t name: check
w 3 00 00020001
w 0 00 01010101
w 0 01 01010101
w 0 02 ff01ff01
w 0 03 ff01ff01
w 0 04 00030000
w 0 05 02000000
w 0 06 00000500
w 0 07 000000fe
w 2 00 00000004
w 2 01 fffffffa
w 2 02 00000000
w 2 03 00000064
w 1 00 00020001
w 1 01 00010003
w 1 02 00000001
w 1 03 00030005
m 0000 16 02 00 01 01 03 01 02 02 05 fe 04 06 04 04 04 04
m 0010 16 ff fe fd fc 00 00 00 00 10 00 00 00 01 01 01 02
m 0100 16 08 08 08 08 fc fc fc fc 00 00 00 00 00 00 00 00
m 0110 16 01 02 03 06 00 00 00 00 00 00 00 00 00 00 00 00
e 04 f4 0b 48
s 4 0000
t requant
w 0 00 7f7f7f7f
w 0 01 7f7f7f7f
w 0 02 80808080
w 0 03 80808080
w 1 00 00000001
w 1 01 00000001
e 7f 80 0b 48
s 4 0000
t saturation
w 0 00 01010101
w 0 01 01010101
w 0 02 ff01ff01
w 0 03 ff01ff01
w 1 00 00020001
w 1 01 00010003
e 04 f4 0b 48
e 02 0d 00 2e
s 4 0000
s 4 0100
t two_images
w 1 02 0000fffe
e 04 f4 ea 48
s 4 0000
t param_rewrite

// ==== tb/tb_gap_fc.sv ====
`timescale 1ns/1ps

module tb_gap_fc;
    import gap_fc_pkg::*;

    localparam int TIMEOUT = 5000;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic [DIM_W-1:0]     pix_count;
    logic [ADDR_W-1:0]    fm_base;
    logic                 busy;
    logic                 done;
    logic                 fm_rd_en;
    logic [ADDR_W-1:0]    fm_rd_addr;
    act_t                 fm_rd_data;
    logic                 param_wr_en;
    logic [SEL_W-1:0]     param_wr_sel;
    logic [PW_ADDR_W-1:0] param_wr_addr;
    logic [31:0]          param_wr_data;
    logic                 res_valid;
    logic [OUT_IDX_W-1:0] res_idx;
    act_t                 res_data;

    act_t                 fm_mem [65536];
    act_t                 exp_q [$];
    act_t                 res_q [$];
    logic [OUT_IDX_W-1:0] idx_q [$];
    int                   done_cnt;
    int                   n_started;
    int                   errors;
    int                   checks;
    int                   tests;
    logic                 aborted;

    gap_fc_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (fm_rd_en) begin
            fm_rd_data <= #5 fm_mem[fm_rd_addr];       // data shows up one cycle after the read
        end
    end

    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            res_q.push_back(res_data);
            idx_q.push_back(res_idx);
        end
        if (rst_n && done) begin
            done_cnt++;
        end
    end

    task automatic check_act(input act_t got, input act_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_idx(input logic [OUT_IDX_W-1:0] got, input logic [OUT_IDX_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: result index got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            $display("Mismatch at %0t: %s count got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic write_param(input logic [SEL_W-1:0] sel, input logic [PW_ADDR_W-1:0] addr,
                               input logic [31:0] data);
        param_wr_en   = 1'b1;
        param_wr_sel  = sel;
        param_wr_addr = addr;
        param_wr_data = data;
        @(posedge clk);
        #5;
        param_wr_en = 1'b0;
    endtask

    task automatic start_image(input logic [DIM_W-1:0] pix, input logic [ADDR_W-1:0] base);
        int n;
        n = 0;
        repeat ($urandom % 4) begin
            @(posedge clk);
            #5;
        end
        while (busy && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (busy) begin
            $display("timeout: busy stayed high, image could not be started");
            aborted = 1'b1;
        end else begin
            pix_count = pix;
            fm_base   = base;
            start     = 1'b1;
            @(posedge clk);
            #5;
            start = 1'b0;
            n_started++;
        end
    endtask

    task automatic wait_for_done(input int count);
        int n;
        n = 0;
        while (done_cnt < count && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (done_cnt < count) begin
            $display("timeout: only %0d of %0d images finished", done_cnt, count);
            aborted = 1'b1;
        end
    endtask

    task automatic run_check(input logic [8*32-1:0] name);
        int err_start;
        err_start = errors;
        wait_for_done(n_started);
        if (!aborted) begin
            check_count(res_q.size(), exp_q.size(), "result");
            check_count(done_cnt, n_started, "done pulse");
            for (int k = 0; k < res_q.size() && k < exp_q.size(); k++) begin
                check_idx(idx_q[k], OUT_IDX_W'(k % OUT_CH));    // outputs leave in index order
                check_act(res_q[k], exp_q[k], "result value");
            end
        end
        tests++;
        $display("test %0s: %s", name, (errors == err_start && !aborted) ? "ok" : "FAILED");
        exp_q.delete();
        res_q.delete();
        idx_q.delete();
        done_cnt  = 0;
        n_started = 0;
    endtask

    initial begin
        int                   fd;
        int                   code;
        int                   n;
        logic [8*32-1:0]      kind;
        logic [8*32-1:0]      name;
        logic [8*128-1:0]     line;
        logic [SEL_W-1:0]     sel;
        logic [PW_ADDR_W-1:0] addr;
        logic [31:0]          data;
        logic [ADDR_W-1:0]    maddr;
        logic [DIM_W-1:0]     pix;
        act_t                 val;
        n = $urandom(86);
        rst_n = 1'b0;
        start = 1'b0;
        pix_count = '0;
        fm_base = '0;
        fm_rd_data = '0;
        param_wr_en = 1'b0;
        param_wr_sel = '0;
        param_wr_addr = '0;
        param_wr_data = '0;
        done_cnt = 0;
        n_started = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        aborted = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            fm_mem[a] = act_t'(a ^ (a >> 8));               // background pattern over the full address
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(res_valid, 1'b0, "res_valid after reset");
        tests++;
        $display("test reset: %s", (errors == 0) ? "ok" : "FAILED");
        fd = $fopen("tb/gap_fc_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/gap_fc_stim.txt");
            aborted = 1'b1;
        end else begin
            code = $fscanf(fd, "%s", kind);
            while (code == 1 && !aborted) begin
                case (kind)
                    "#": code = $fgets(line, fd);
                    "w": begin
                        code = $fscanf(fd, "%h %h %h", sel, addr, data);
                        write_param(sel, addr, data);
                    end
                    "m": begin
                        code = $fscanf(fd, "%h %d", maddr, n);
                        for (int k = 0; k < n; k++) begin
                            code = $fscanf(fd, "%h", val);
                            fm_mem[maddr + ADDR_W'(k)] = val;
                        end
                    end
                    "e": begin
                        for (int k = 0; k < OUT_CH; k++) begin
                            code = $fscanf(fd, "%h", val);
                            exp_q.push_back(val);
                        end
                    end
                    "s": begin
                        code = $fscanf(fd, "%d %h", pix, maddr);
                        start_image(pix, maddr);
                    end
                    "t": begin
                        code = $fscanf(fd, "%s", name);
                        run_check(name);
                    end
                    default: begin
                        $display("unknown record in stimulus file: %0s", kind);
                        aborted = 1'b1;
                    end
                endcase
                code = $fscanf(fd, "%s", kind);
            end
            $fclose(fd);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog/chan_buf_if.sv ====
`timescale 1ns/1ps

interface chan_buf_if;
    import gap_fc_pkg::*;

    logic                wr_en;
    logic [CH_IDX_W-1:0] wr_idx;
    act_t                wr_data;
    logic                wr_last;        // marks the final channel and closes the write bank
    logic                wr_ready;
    logic [CH_IDX_W-1:0] rd_idx;
    act_t                rd_data;
    logic                rd_valid;
    logic                rd_release;     // one cycle pulse frees the read bank

    modport pool (
        output wr_en, wr_idx, wr_data, wr_last,
        input  wr_ready
    );

    modport store (
        input  wr_en, wr_idx, wr_data, wr_last, rd_idx, rd_release,
        output wr_ready, rd_data, rd_valid
    );

    modport cls (
        output rd_idx, rd_release,
        input  rd_data, rd_valid
    );

endinterface

// ==== verilog/chan_pingpong.sv ====
`timescale 1ns/1ps

module chan_pingpong (
    input  logic       clk,
    input  logic       rst_n,
    chan_buf_if.store  cbuf
);
    import gap_fc_pkg::*;

    act_t       mem [2][IN_CH];
    logic [1:0] full;
    logic       wr_ptr;
    logic       rd_ptr;

    always_ff @(posedge clk) begin
        if (cbuf.wr_en) begin
            mem[wr_ptr][cbuf.wr_idx] <= cbuf.wr_data;
        end
    end

    // the write bank is always empty and the read bank full, so both may change at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full   <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (cbuf.wr_en && cbuf.wr_last) begin
                full[wr_ptr] <= 1'b1;
                wr_ptr       <= !wr_ptr;
            end
            if (cbuf.rd_release) begin
                full[rd_ptr] <= 1'b0;
                rd_ptr       <= !rd_ptr;
            end
        end
    end

    assign cbuf.wr_ready = !full[wr_ptr];
    assign cbuf.rd_valid = full[rd_ptr];
    assign cbuf.rd_data  = mem[rd_ptr][cbuf.rd_idx];           // read is combinational

endmodule

// ==== verilog/fc_layer.sv ====
`timescale 1ns/1ps

module fc_layer (
    input  logic                             clk,
    input  logic                             rst_n,
    chan_buf_if.cls                          cbuf,
    output logic [gap_fc_pkg::OUT_IDX_W-1:0] w_out_idx,
    output logic [gap_fc_pkg::CH_IDX_W-1:0]  w_in_idx,
    input  gap_fc_pkg::act_t                 w_byte,
    input  gap_fc_pkg::acc_t                 fc_bias,
    input  gap_fc_pkg::rq_t                  fc_rq,
    output logic                             res_valid,
    output logic [gap_fc_pkg::OUT_IDX_W-1:0] res_idx,
    output gap_fc_pkg::act_t                 res_data,
    output logic                             done
);
    import gap_fc_pkg::*;

    logic [FC_ST_W-1:0]   state;
    logic [OUT_IDX_W-1:0] out_idx;
    logic [CH_IDX_W-1:0]  in_idx;
    logic                 last_in;
    logic                 last_out;
    acc_t                 acc;
    acc_t                 prod;

    assign last_in  = in_idx == CH_IDX_W'(IN_CH - 1);
    assign last_out = out_idx == OUT_IDX_W'(OUT_CH - 1);
    assign prod     = cbuf.rd_data * w_byte;

    assign w_out_idx   = out_idx;
    assign w_in_idx    = in_idx;
    assign cbuf.rd_idx = in_idx;                               // same index walks buffer and weights

    assign res_valid = state == FS_EMIT;
    assign res_idx   = out_idx;
    assign res_data  = requant(acc, fc_rq);

    assign cbuf.rd_release = state == FS_REL;
    assign done            = state == FS_REL;

    always_ff @(posedge clk) begin
        if (state == FS_BIAS) begin
            acc <= fc_bias;
        end else if (state == FS_MAC) begin
            acc <= acc + prod;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= FS_IDLE;
            out_idx <= '0;
            in_idx  <= '0;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (cbuf.rd_valid) begin
                        out_idx <= '0;
                        state   <= FS_BIAS;
                    end
                end
                FS_BIAS: begin
                    in_idx <= '0;
                    state  <= FS_MAC;
                end
                FS_MAC: begin
                    in_idx <= in_idx + CH_IDX_W'(1);
                    if (last_in) begin
                        state <= FS_EMIT;
                    end
                end
                FS_EMIT: begin
                    out_idx <= out_idx + OUT_IDX_W'(1);
                    state   <= last_out ? FS_REL : FS_BIAS;
                end
                default: begin
                    state <= FS_IDLE;                          // bank is handed back this cycle
                end
            endcase
        end
    end

endmodule

// ==== verilog/gap_fc_pkg.sv ====
package gap_fc_pkg;

    localparam int DATA_W    = 8;
    localparam int ACC_W     = 32;
    localparam int ADDR_W    = 16;
    localparam int DIM_W     = 16;
    localparam int IN_CH     = 8;
    localparam int OUT_CH    = 4;
    localparam int CH_IDX_W  = 3;
    localparam int OUT_IDX_W = 2;
    localparam int PW_ADDR_W = 8;
    localparam int SEL_W     = 2;

    localparam logic [SEL_W-1:0] SEL_FC_W    = 2'd0;
    localparam logic [SEL_W-1:0] SEL_FC_RQ   = 2'd1;
    localparam logic [SEL_W-1:0] SEL_FC_BIAS = 2'd2;
    localparam logic [SEL_W-1:0] SEL_GAP_RQ  = 2'd3;

    localparam int POOL_ST_W = 2;
    localparam logic [POOL_ST_W-1:0] PS_IDLE  = 2'd0;
    localparam logic [POOL_ST_W-1:0] PS_READ  = 2'd1;
    localparam logic [POOL_ST_W-1:0] PS_DRAIN = 2'd2;
    localparam logic [POOL_ST_W-1:0] PS_WRITE = 2'd3;

    localparam int FC_ST_W = 3;
    localparam logic [FC_ST_W-1:0] FS_IDLE = 3'd0;
    localparam logic [FC_ST_W-1:0] FS_BIAS = 3'd1;
    localparam logic [FC_ST_W-1:0] FS_MAC  = 3'd2;
    localparam logic [FC_ST_W-1:0] FS_EMIT = 3'd3;
    localparam logic [FC_ST_W-1:0] FS_REL  = 3'd4;

    typedef logic signed [DATA_W-1:0] act_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef struct packed {
        logic [10:0]        pad;
        logic [4:0]         shift;
        logic signed [15:0] mult;
    } rq_t;

    typedef union packed {
        act_t [3:0] w;                          // lane 0 sits in the low byte
        rq_t        rq;
    } param_word_u;

    function automatic act_t requant(acc_t acc, rq_t rq);
        logic signed [15:0] mult;
        logic signed [47:0] prod;
        logic signed [47:0] shifted;
        mult = rq.mult;
        prod = acc * mult;
        shifted = prod >>> rq.shift;            // arithmetic shift rounds toward minus infinity
        if (shifted > 127) begin
            return act_t'(127);
        end
        if (shifted < -128) begin
            return act_t'(-128);
        end
        return shifted[DATA_W-1:0];
    endfunction

endpackage

// ==== verilog/gap_fc_top.sv ====
`timescale 1ns/1ps

module gap_fc_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [gap_fc_pkg::DIM_W-1:0]     pix_count,
    input  logic [gap_fc_pkg::ADDR_W-1:0]    fm_base,
    output logic                             busy,
    output logic                             done,
    output logic                             fm_rd_en,
    output logic [gap_fc_pkg::ADDR_W-1:0]    fm_rd_addr,
    input  gap_fc_pkg::act_t                 fm_rd_data,
    input  logic                             param_wr_en,
    input  logic [gap_fc_pkg::SEL_W-1:0]     param_wr_sel,
    input  logic [gap_fc_pkg::PW_ADDR_W-1:0] param_wr_addr,
    input  logic [31:0]                      param_wr_data,
    output logic                             res_valid,
    output logic [gap_fc_pkg::OUT_IDX_W-1:0] res_idx,
    output gap_fc_pkg::act_t                 res_data
);
    import gap_fc_pkg::*;

    rq_t                  gap_rq;
    rq_t                  fc_rq;
    act_t                 w_byte;
    acc_t                 fc_bias;
    logic [OUT_IDX_W-1:0] w_out_idx;
    logic [CH_IDX_W-1:0]  w_in_idx;

    chan_buf_if u_chan ();

    param_regs u_params (
        .clk(clk),
        .rst_n(rst_n),
        .param_wr_en(param_wr_en),
        .param_wr_sel(param_wr_sel),
        .param_wr_addr(param_wr_addr),
        .param_wr_data(param_wr_data),
        .gap_rq(gap_rq),
        .w_out_idx(w_out_idx),
        .w_in_idx(w_in_idx),
        .w_byte(w_byte),
        .fc_bias(fc_bias),
        .fc_rq(fc_rq)
    );

    gap_pool u_pool (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .pix_count(pix_count),
        .fm_base(fm_base),
        .gap_rq(gap_rq),
        .busy(busy),
        .fm_rd_en(fm_rd_en),
        .fm_rd_addr(fm_rd_addr),
        .fm_rd_data(fm_rd_data),
        .cbuf(u_chan.pool)
    );

    chan_pingpong u_buf (
        .clk(clk),
        .rst_n(rst_n),
        .cbuf(u_chan.store)
    );

    fc_layer u_fc (
        .clk(clk),
        .rst_n(rst_n),
        .cbuf(u_chan.cls),
        .w_out_idx(w_out_idx),
        .w_in_idx(w_in_idx),
        .w_byte(w_byte),
        .fc_bias(fc_bias),
        .fc_rq(fc_rq),
        .res_valid(res_valid),
        .res_idx(res_idx),
        .res_data(res_data),
        .done(done)
    );

endmodule

// ==== verilog/gap_pool.sv ====
`timescale 1ns/1ps

module gap_pool (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [gap_fc_pkg::DIM_W-1:0]  pix_count,
    input  logic [gap_fc_pkg::ADDR_W-1:0] fm_base,
    input  gap_fc_pkg::rq_t               gap_rq,
    output logic                          busy,
    output logic                          fm_rd_en,
    output logic [gap_fc_pkg::ADDR_W-1:0] fm_rd_addr,
    input  gap_fc_pkg::act_t              fm_rd_data,
    chan_buf_if.pool                      cbuf
);
    import gap_fc_pkg::*;

    logic [POOL_ST_W-1:0] state;
    logic [DIM_W-1:0]     pix_q;
    logic [DIM_W-1:0]     pix_idx;
    logic [ADDR_W-1:0]    rd_addr;
    logic [CH_IDX_W-1:0]  ch_idx;
    logic                 data_vld;
    logic                 last_pix;
    logic                 last_ch;
    logic                 accept;
    acc_t                 sum;

    assign last_pix = pix_idx == pix_q - DIM_W'(1);
    assign last_ch  = ch_idx == CH_IDX_W'(IN_CH - 1);
    assign busy     = (state != PS_IDLE) || !cbuf.wr_ready;    // no free bank counts as busy
    assign accept   = start && !busy;

    assign fm_rd_en   = state == PS_READ;
    assign fm_rd_addr = rd_addr;

    assign cbuf.wr_en   = state == PS_WRITE;
    assign cbuf.wr_idx  = ch_idx;
    assign cbuf.wr_data = requant(sum, gap_rq);
    assign cbuf.wr_last = (state == PS_WRITE) && last_ch;

    // channels are contiguous in memory so one running address covers the map
    always_ff @(posedge clk) begin
        if (accept) begin
            pix_q   <= pix_count;
            rd_addr <= fm_base;
        end else if (fm_rd_en) begin
            rd_addr <= rd_addr + ADDR_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= PS_IDLE;
            pix_idx  <= '0;
            ch_idx   <= '0;
            data_vld <= 1'b0;
            sum      <= '0;
        end else begin
            data_vld <= fm_rd_en;                              // memory answers one cycle later
            if (data_vld) begin
                sum <= sum + acc_t'(fm_rd_data);
            end
            case (state)
                PS_IDLE: begin
                    if (accept) begin
                        pix_idx <= '0;
                        ch_idx  <= '0;
                        state   <= PS_READ;
                    end
                end
                PS_READ: begin
                    pix_idx <= pix_idx + DIM_W'(1);
                    if (last_pix) begin
                        pix_idx <= '0;
                        state   <= PS_DRAIN;
                    end
                end
                PS_DRAIN: begin
                    state <= PS_WRITE;                         // last pixel lands in sum here
                end
                default: begin
                    sum    <= '0;
                    ch_idx <= ch_idx + CH_IDX_W'(1);
                    state  <= last_ch ? PS_IDLE : PS_READ;
                end
            endcase
        end
    end

endmodule

// ==== verilog/param_regs.sv ====
`timescale 1ns/1ps

module param_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             param_wr_en,
    input  logic [gap_fc_pkg::SEL_W-1:0]     param_wr_sel,
    input  logic [gap_fc_pkg::PW_ADDR_W-1:0] param_wr_addr,
    input  logic [31:0]                      param_wr_data,
    output gap_fc_pkg::rq_t                  gap_rq,
    input  logic [gap_fc_pkg::OUT_IDX_W-1:0] w_out_idx,
    input  logic [gap_fc_pkg::CH_IDX_W-1:0]  w_in_idx,
    output gap_fc_pkg::act_t                 w_byte,
    output gap_fc_pkg::acc_t                 fc_bias,
    output gap_fc_pkg::rq_t                  fc_rq
);
    import gap_fc_pkg::*;

    act_t        w_mem [OUT_CH*IN_CH];
    acc_t        bias_mem [OUT_CH];
    rq_t         rq_mem [OUT_CH];
    param_word_u pw;
    logic [OUT_IDX_W+CH_IDX_W-3:0] w_word;
    logic [OUT_IDX_W-1:0]          out_sel;
    logic                          w_addr_ok;
    logic                          o_addr_ok;

    assign pw        = param_wr_data;
    assign w_word    = param_wr_addr[OUT_IDX_W+CH_IDX_W-3:0];
    assign out_sel   = param_wr_addr[OUT_IDX_W-1:0];
    assign w_addr_ok = param_wr_addr < PW_ADDR_W'(OUT_CH * IN_CH / 4);
    assign o_addr_ok = param_wr_addr < PW_ADDR_W'(OUT_CH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < OUT_CH * IN_CH; i++) begin
                w_mem[i] <= '0;
            end
            for (int o = 0; o < OUT_CH; o++) begin
                bias_mem[o] <= '0;
                rq_mem[o]   <= '0;
            end
            gap_rq <= '0;
        end else if (param_wr_en) begin
            case (param_wr_sel)
                SEL_FC_W: begin
                    if (w_addr_ok) begin
                        for (int l = 0; l < 4; l++) begin
                            w_mem[{w_word, 2'(l)}] <= pw.w[l]; // four weights per word
                        end
                    end
                end
                SEL_FC_RQ: begin
                    if (o_addr_ok) begin
                        rq_mem[out_sel] <= pw.rq;
                    end
                end
                SEL_FC_BIAS: begin
                    if (o_addr_ok) begin
                        bias_mem[out_sel] <= acc_t'(param_wr_data);
                    end
                end
                SEL_GAP_RQ: begin
                    gap_rq <= pw.rq;
                end
            endcase
        end
    end

    assign w_byte  = w_mem[{w_out_idx, w_in_idx}];             // byte index is o*IN_CH + i
    assign fc_bias = bias_mem[w_out_idx];
    assign fc_rq   = rq_mem[w_out_idx];

endmodule
